//--- hw/trace_settings.svh
`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

// Record kind codes
`define TRACE_KIND_INST  4'd1
`define TRACE_KIND_LOAD  4'd2
`define TRACE_KIND_STORE 4'd3
`define TRACE_KIND_REG   4'd4
`define TRACE_KIND_CSR   4'd5
`define TRACE_KIND_TRAP  4'd6

// Field widths inside one record
`define TRACE_KIND_W 4
`define TRACE_TAG_W  12
`define TRACE_WORD_W 32
`define TRACE_REC_W  80

// Number of output buffer entries as a power of two
`define TRACE_FIFO_DEPTH 4

`endif

//--- hw/trace_pkg.sv
`include "trace_settings.svh"

package trace_pkg;

    // Event fields
    typedef logic [`TRACE_WORD_W-1:0] word_t;
    typedef logic [1:0]               prv_t;
    typedef logic [3:0]               byte_mask_t;
    typedef logic [4:0]               reg_addr_t;
    typedef logic [11:0]              csr_addr_t;

    // A record packs kind, tag, word a and word b from the top down
    typedef logic [`TRACE_KIND_W-1:0] rec_kind_t;
    typedef logic [`TRACE_TAG_W-1:0]  rec_tag_t;
    typedef logic [`TRACE_REC_W-1:0]  trace_rec_t;

    // One bit each for inst, mem, reg, csr and trap from bit 0 up
    typedef logic [4:0] rec_sel_t;

    typedef enum logic {
        IDLE,
        EMIT
    } enc_state_t;

endpackage

//--- hw/retire_capture.sv
`timescale 1ns/1ps

module retire_capture (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic                  inst_valid,
    input  trace_pkg::word_t      pc,
    input  trace_pkg::word_t      inst,
    input  trace_pkg::prv_t       prv,
    input  logic                  mem_req,
    input  logic                  mem_wr,
    input  trace_pkg::byte_mask_t mem_byte,
    input  trace_pkg::word_t      mem_addr,
    input  trace_pkg::word_t      mem_rdata,
    input  trace_pkg::word_t      mem_wdata,
    input  logic                  rd_wr,
    input  trace_pkg::reg_addr_t  rd_addr,
    input  trace_pkg::word_t      rd_data,
    input  logic                  csr_wr,
    input  trace_pkg::csr_addr_t  csr_waddr,
    input  trace_pkg::word_t      csr_wdata,
    input  logic                  trap_en,
    input  trace_pkg::word_t      mcause,
    input  trace_pkg::word_t      mtval,
    input  logic                  cap_ready,
    output logic                  cap_valid,
    output trace_pkg::rec_sel_t   cap_sel,
    output trace_pkg::prv_t       cap_prv,
    output trace_pkg::word_t      cap_pc,
    output trace_pkg::word_t      cap_inst,
    output logic                  cap_mem_wr,
    output trace_pkg::byte_mask_t cap_mem_byte,
    output trace_pkg::word_t      cap_mem_addr,
    output trace_pkg::word_t      cap_mem_data,
    output trace_pkg::reg_addr_t  cap_rd_addr,
    output trace_pkg::word_t      cap_rd_data,
    output trace_pkg::csr_addr_t  cap_csr_addr,
    output trace_pkg::word_t      cap_csr_data,
    output trace_pkg::word_t      cap_mcause,
    output trace_pkg::word_t      cap_mtval
);

    trace_pkg::rec_sel_t sel;
    trace_pkg::word_t    mem_src;
    trace_pkg::word_t    mem_kept;
    logic                accept;

    assign sel      = {trap_en, csr_wr, rd_wr, mem_req, inst_valid};
    assign in_ready = !cap_valid || cap_ready;
    assign accept   = in_valid && in_ready;

    // Only the enabled byte lanes survive
    always_comb begin
        mem_src = mem_wr ? mem_wdata : mem_rdata;
        for (int i = 0; i < 4; i++) begin
            mem_kept[i*8 +: 8] = mem_byte[i] ? mem_src[i*8 +: 8] : 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cap_valid <= 1'b0;
        end else if (accept) begin
            // An event with nothing to report is swallowed here
            cap_valid <= |sel;
        end else if (cap_ready) begin
            cap_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cap_sel      <= sel;
            cap_prv      <= prv;
            cap_pc       <= pc;
            cap_inst     <= inst;
            cap_mem_wr   <= mem_wr;
            cap_mem_byte <= mem_byte;
            cap_mem_addr <= {mem_addr[31:2], 2'b00};
            cap_mem_data <= mem_kept;
            cap_rd_addr  <= rd_addr;
            cap_rd_data  <= (rd_addr == 5'd0) ? 32'h0 : rd_data;
            cap_csr_addr <= csr_waddr;
            cap_csr_data <= csr_wdata;
            cap_mcause   <= mcause;
            cap_mtval    <= mtval;
        end
    end

    // Held event must not move until the encoder releases it
    assert property (@(posedge clk) disable iff (rst)
        cap_valid && !cap_ready |=> cap_valid && $stable(cap_sel) && $stable(cap_pc)
            && $stable(cap_inst) && $stable(cap_prv) && $stable(cap_mem_addr)
            && $stable(cap_mem_data) && $stable(cap_rd_data) && $stable(cap_csr_data)
            && $stable(cap_mcause) && $stable(cap_mtval));

    assert property (@(posedge clk) disable iff (rst) cap_valid |-> cap_sel != '0);

endmodule

//--- hw/trace_encoder.sv
`timescale 1ns/1ps
`include "trace_settings.svh"

module trace_encoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cap_valid,
    input  trace_pkg::rec_sel_t   cap_sel,
    input  trace_pkg::prv_t       cap_prv,
    input  trace_pkg::word_t      cap_pc,
    input  trace_pkg::word_t      cap_inst,
    input  logic                  cap_mem_wr,
    input  trace_pkg::byte_mask_t cap_mem_byte,
    input  trace_pkg::word_t      cap_mem_addr,
    input  trace_pkg::word_t      cap_mem_data,
    input  trace_pkg::reg_addr_t  cap_rd_addr,
    input  trace_pkg::word_t      cap_rd_data,
    input  trace_pkg::csr_addr_t  cap_csr_addr,
    input  trace_pkg::word_t      cap_csr_data,
    input  trace_pkg::word_t      cap_mcause,
    input  trace_pkg::word_t      cap_mtval,
    input  logic                  enc_ready,
    output logic                  cap_ready,
    output logic                  enc_valid,
    output trace_pkg::trace_rec_t enc_rec
);

    trace_pkg::enc_state_t state;
    trace_pkg::rec_sel_t   pend;
    trace_pkg::rec_sel_t   work;
    trace_pkg::rec_sel_t   low;
    trace_pkg::rec_sel_t   rest;
    trace_pkg::rec_kind_t  kind;
    trace_pkg::rec_tag_t   tag;
    trace_pkg::word_t      word_a;
    trace_pkg::word_t      word_b;
    logic                  last;
    logic                  fire;

    // First record of an event comes straight from cap_sel, the rest from pend
    assign work = (state == trace_pkg::EMIT) ? pend : cap_sel;
    assign low  = work & (~work + 5'd1);
    assign rest = work & ~low;
    assign last = (rest == '0);

    assign enc_valid = cap_valid;
    assign fire      = enc_valid && enc_ready;
    assign cap_ready = fire && last;

    always_comb begin
        kind   = '0;
        tag    = '0;
        word_a = '0;
        word_b = '0;
        if (work[0]) begin
            kind   = `TRACE_KIND_INST;
            tag    = {10'd0, cap_prv};
            word_a = cap_pc;
            word_b = cap_inst;
        end else if (work[1]) begin
            kind   = cap_mem_wr ? `TRACE_KIND_STORE : `TRACE_KIND_LOAD;
            tag    = {8'd0, cap_mem_byte};
            word_a = cap_mem_addr;
            word_b = cap_mem_data;
        end else if (work[2]) begin
            kind   = `TRACE_KIND_REG;
            tag    = {7'd0, cap_rd_addr};
            word_b = cap_rd_data;
        end else if (work[3]) begin
            kind   = `TRACE_KIND_CSR;
            tag    = cap_csr_addr;
            word_b = cap_csr_data;
        end else if (work[4]) begin
            kind   = `TRACE_KIND_TRAP;
            word_a = cap_mcause;
            word_b = cap_mtval;
        end
    end

    assign enc_rec = {kind, tag, word_a, word_b};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= trace_pkg::IDLE;
            pend  <= '0;
        end else if (fire) begin
            if (last) begin
                state <= trace_pkg::IDLE;
                pend  <= '0;
            end else begin
                state <= trace_pkg::EMIT;
                pend  <= rest;
            end
        end
    end

    // A stalled record is held as is until the FIFO takes it
    assert property (@(posedge clk) disable iff (rst)
        enc_valid && !enc_ready |=> enc_valid && $stable(enc_rec));

endmodule

//--- hw/trace_fifo.sv
`timescale 1ns/1ps
`include "trace_settings.svh"

module trace_fifo #(
    parameter int DEPTH = `TRACE_FIFO_DEPTH
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enc_valid,
    input  trace_pkg::trace_rec_t enc_rec,
    output logic                  enc_ready,
    output logic                  out_valid,
    output trace_pkg::trace_rec_t out_rec,
    input  logic                  out_ready
);

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

    trace_pkg::trace_rec_t mem [DEPTH];
    logic [AW-1:0]         wr_ptr;
    logic [AW-1:0]         rd_ptr;
    logic [AW:0]           count;
    logic                  wr_en;
    logic                  rd_en;

    assign enc_ready = (count != FULL_CNT);
    assign out_valid = (count != '0);
    assign out_rec   = mem[rd_ptr];

    assign wr_en = enc_valid && enc_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= enc_rec;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{AW{1'b0}}, wr_en} - {{AW{1'b0}}, rd_en};
        end
    end

    // Full and not draining, so the write side must stay put
    assert property (@(posedge clk) disable iff (rst)
        count == FULL_CNT && !rd_en |=> $stable(wr_ptr) && count == FULL_CNT);

endmodule

//--- hw/commit_trace_top.sv
`timescale 1ns/1ps

module commit_trace_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic                  inst_valid,
    input  trace_pkg::word_t      pc,
    input  trace_pkg::word_t      inst,
    input  trace_pkg::prv_t       prv,
    input  logic                  mem_req,
    input  logic                  mem_wr,
    input  trace_pkg::byte_mask_t mem_byte,
    input  trace_pkg::word_t      mem_addr,
    input  trace_pkg::word_t      mem_rdata,
    input  trace_pkg::word_t      mem_wdata,
    input  logic                  rd_wr,
    input  trace_pkg::reg_addr_t  rd_addr,
    input  trace_pkg::word_t      rd_data,
    input  logic                  csr_wr,
    input  trace_pkg::csr_addr_t  csr_waddr,
    input  trace_pkg::word_t      csr_wdata,
    input  logic                  trap_en,
    input  trace_pkg::word_t      mcause,
    input  trace_pkg::word_t      mtval,
    output logic                  out_valid,
    input  logic                  out_ready,
    output trace_pkg::trace_rec_t out_rec
);

    logic                  cap_valid;
    logic                  cap_ready;
    trace_pkg::rec_sel_t   cap_sel;
    trace_pkg::prv_t       cap_prv;
    trace_pkg::word_t      cap_pc;
    trace_pkg::word_t      cap_inst;
    logic                  cap_mem_wr;
    trace_pkg::byte_mask_t cap_mem_byte;
    trace_pkg::word_t      cap_mem_addr;
    trace_pkg::word_t      cap_mem_data;
    trace_pkg::reg_addr_t  cap_rd_addr;
    trace_pkg::word_t      cap_rd_data;
    trace_pkg::csr_addr_t  cap_csr_addr;
    trace_pkg::word_t      cap_csr_data;
    trace_pkg::word_t      cap_mcause;
    trace_pkg::word_t      cap_mtval;
    logic                  enc_valid;
    logic                  enc_ready;
    trace_pkg::trace_rec_t enc_rec;

    retire_capture cap0 (
        .clk, .rst, .in_valid, .in_ready,
        .inst_valid, .pc, .inst, .prv,
        .mem_req, .mem_wr, .mem_byte, .mem_addr, .mem_rdata, .mem_wdata,
        .rd_wr, .rd_addr, .rd_data,
        .csr_wr, .csr_waddr, .csr_wdata,
        .trap_en, .mcause, .mtval,
        .cap_ready, .cap_valid, .cap_sel, .cap_prv, .cap_pc, .cap_inst,
        .cap_mem_wr, .cap_mem_byte, .cap_mem_addr, .cap_mem_data,
        .cap_rd_addr, .cap_rd_data, .cap_csr_addr, .cap_csr_data,
        .cap_mcause, .cap_mtval
    );

    trace_encoder enc0 (
        .clk, .rst, .cap_valid, .cap_sel, .cap_prv, .cap_pc, .cap_inst,
        .cap_mem_wr, .cap_mem_byte, .cap_mem_addr, .cap_mem_data,
        .cap_rd_addr, .cap_rd_data, .cap_csr_addr, .cap_csr_data,
        .cap_mcause, .cap_mtval,
        .enc_ready, .cap_ready, .enc_valid, .enc_rec
    );

    trace_fifo fifo0 (
        .clk, .rst, .enc_valid, .enc_rec, .enc_ready,
        .out_valid, .out_rec, .out_ready
    );

endmodule

//--- test/trace_checker.sv
`timescale 1ns/1ps
`include "trace_settings.svh"

module trace_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic                  in_ready,
    input  logic                  inst_valid,
    input  trace_pkg::word_t      pc,
    input  trace_pkg::word_t      inst,
    input  trace_pkg::prv_t       prv,
    input  logic                  mem_req,
    input  logic                  mem_wr,
    input  trace_pkg::byte_mask_t mem_byte,
    input  trace_pkg::word_t      mem_addr,
    input  trace_pkg::word_t      mem_rdata,
    input  trace_pkg::word_t      mem_wdata,
    input  logic                  rd_wr,
    input  trace_pkg::reg_addr_t  rd_addr,
    input  trace_pkg::word_t      rd_data,
    input  logic                  csr_wr,
    input  trace_pkg::csr_addr_t  csr_waddr,
    input  trace_pkg::word_t      csr_wdata,
    input  logic                  trap_en,
    input  trace_pkg::word_t      mcause,
    input  trace_pkg::word_t      mtval,
    input  logic                  out_valid,
    input  logic                  out_ready,
    input  trace_pkg::trace_rec_t out_rec,
    output int                    errors,
    output int                    pending
);

    trace_pkg::trace_rec_t exp_q[$];
    logic                  was_rst = 1'b1;

    function automatic trace_pkg::trace_rec_t make_rec(input trace_pkg::rec_kind_t kind,
        input trace_pkg::rec_tag_t tag, input trace_pkg::word_t a, input trace_pkg::word_t b);
        return {kind, tag, a, b};
    endfunction

    // Expected records of the event on the input ports, in emission order
    function automatic void predict_event();
        trace_pkg::rec_kind_t mem_kind;
        trace_pkg::word_t     lanes;
        trace_pkg::word_t     reg_val;
        mem_kind = mem_wr ? `TRACE_KIND_STORE : `TRACE_KIND_LOAD;
        lanes    = (mem_wr ? mem_wdata : mem_rdata)
                   & {{8{mem_byte[3]}}, {8{mem_byte[2]}}, {8{mem_byte[1]}}, {8{mem_byte[0]}}};
        reg_val  = (rd_addr == 5'd0) ? 32'h0 : rd_data;
        if (inst_valid) begin
            exp_q.push_back(make_rec(`TRACE_KIND_INST, {10'd0, prv}, pc, inst));
        end
        if (mem_req) begin
            exp_q.push_back(make_rec(mem_kind, {8'd0, mem_byte}, {mem_addr[31:2], 2'b00}, lanes));
        end
        if (rd_wr) begin
            exp_q.push_back(make_rec(`TRACE_KIND_REG, {7'd0, rd_addr}, 32'h0, reg_val));
        end
        if (csr_wr) begin
            exp_q.push_back(make_rec(`TRACE_KIND_CSR, csr_waddr, 32'h0, csr_wdata));
        end
        if (trap_en) begin
            exp_q.push_back(make_rec(`TRACE_KIND_TRAP, 12'h0, mcause, mtval));
        end
    endfunction

    task automatic report_field(input string name, input logic [31:0] got,
        input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED out_rec.%s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    always @(posedge clk) begin : watch
        trace_pkg::trace_rec_t exp;
        if (rst) begin
            exp_q.delete();
            errors = 0;
        end else begin
            if (was_rst) begin
                if (out_valid !== 1'b0) begin
                    $display("FAILED out_valid after reset: got %h, expected 0", out_valid);
                    errors++;
                end
                if (in_ready !== 1'b1) begin
                    $display("FAILED in_ready after reset: got %h, expected 1", in_ready);
                    errors++;
                end
            end
            if (in_valid && in_ready) begin
                predict_event();
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("record %h came out at %0t with none expected", out_rec, $time);
                    errors++;
                end else begin
                    exp = exp_q.pop_front();
                    if (out_rec !== exp) begin
                        errors++;
                        report_field("kind", {28'd0, out_rec[79:76]}, {28'd0, exp[79:76]});
                        report_field("tag", {20'd0, out_rec[75:64]}, {20'd0, exp[75:64]});
                        report_field("word_a", out_rec[63:32], exp[63:32]);
                        report_field("word_b", out_rec[31:0], exp[31:0]);
                    end
                end
            end
        end
        was_rst = rst;
        pending = exp_q.size();
    end

endmodule

//--- test/tb_commit_trace.sv
`timescale 1ns/1ps

module tb_commit_trace;

    localparam int N_DIRECTED = 9;
    localparam int N_RANDOM = 300;
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 40 + 500;

    logic clk = 1'b0;
    logic rst, in_valid, in_ready, out_valid, out_ready;
    logic inst_valid, mem_req, mem_wr, rd_wr, csr_wr, trap_en;
    trace_pkg::word_t pc, inst, mem_addr, mem_rdata, mem_wdata;
    trace_pkg::word_t rd_data, csr_wdata, mcause, mtval;
    trace_pkg::prv_t prv;
    trace_pkg::byte_mask_t mem_byte;
    trace_pkg::reg_addr_t rd_addr;
    trace_pkg::csr_addr_t csr_waddr;
    trace_pkg::trace_rec_t out_rec;
    int errors;
    int pending;
    logic stress = 1'b0;
    logic [31:0] stim_rng = 32'd13668;
    logic [31:0] bp_rng = 32'd13668 ^ 32'h9e37_79b9;

    commit_trace_top dut0 (.*);
    trace_checker chk0 (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    task automatic clear_event();
        {in_valid, inst_valid, mem_req, mem_wr, rd_wr, csr_wr, trap_en} = '0;
        {pc, inst, mem_addr, mem_rdata, mem_wdata} = '0;
        {rd_data, csr_wdata, mcause, mtval} = '0;
        {prv, mem_byte, rd_addr, csr_waddr} = '0;
    endtask

    // in_ready depends only on registered state, so it holds until the next edge
    task automatic send_event();
        logic taken;
        in_valid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            taken = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic random_event();
        logic [31:0] r;
        r = next_rand();
        {trap_en, csr_wr, rd_wr, mem_wr, mem_req, inst_valid} = r[5:0];
        mem_byte = r[9:6];
        prv = r[11:10];
        rd_addr = r[16:12] & {5{r[17]}};
        csr_waddr = r[29:18];
        pc = next_rand();
        inst = next_rand();
        mem_addr = next_rand();
        mem_rdata = next_rand();
        mem_wdata = next_rand();
        rd_data = next_rand();
        csr_wdata = next_rand();
        mcause = next_rand();
        mtval = next_rand();
        send_event();
        repeat (r[31:30]) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Random sink stalls once the stress phase starts
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (stress) begin
                bp_rng = xorshift32(bp_rng);
                out_ready = (bp_rng[1:0] != 2'b00);
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        int drain_cycles;
        rst = 1'b1;
        clear_event();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        {inst_valid, prv, pc, inst} = {1'b1, 2'd3, 32'h8000_0000, 32'h0000_0013};
        send_event();

        // Load, store and x0 write
        clear_event();
        {mem_req, mem_byte, mem_addr} = {1'b1, 4'b0110, 32'h1000_0007};
        {mem_rdata, mem_wdata} = {32'hdead_beef, 32'h1111_2222};
        send_event();
        {mem_wr, mem_byte, mem_addr, mem_wdata} = {1'b1, 4'b1001, 32'h2000_0002, 32'hcafe_f00d};
        send_event();
        clear_event();
        {rd_wr, rd_addr, rd_data} = {1'b1, 5'd0, 32'h1234_5678};
        send_event();

        // Every item at once with an interrupt cause and then an exception cause
        {inst_valid, mem_req, csr_wr, trap_en, prv} = {4'hf, 2'd1};
        {pc, inst, mem_byte, mem_addr} = {32'h8000_0100, 32'h3420_2573, 4'hf, 32'h0000_4000};
        {mem_rdata, rd_addr, rd_data} = {32'h0bad_f00d, 5'd10, 32'h0000_00aa};
        {csr_waddr, csr_wdata, mcause, mtval} = {12'h341, 32'h8000_0104, 32'h8000_0007, 32'h0};
        send_event();
        {mcause, mtval} = {32'h0000_0002, 32'h3420_2573};
        send_event();

        clear_event();
        send_event();
        {csr_wr, csr_waddr, csr_wdata} = {1'b1, 12'h300, 32'h0000_1888};
        send_event();
        clear_event();
        {trap_en, mcause, mtval} = {1'b1, 32'h0000_000b, 32'h0};
        send_event();

        stress = 1'b1;
        repeat (N_RANDOM) random_event();

        // Bounded drain so that lost records show up as missing
        drain_cycles = 0;
        while ((pending != 0 || out_valid) && drain_cycles < 200) begin
            @(posedge clk);
            #1;
            drain_cycles++;
        end
        repeat (10) @(posedge clk);
        #1;
        $display("errors: %0d failed checks, %0d records missing", errors, pending);
        if (errors == 0 && pending == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+hw
hw/trace_pkg.sv
hw/retire_capture.sv
hw/trace_encoder.sv
hw/trace_fifo.sv
hw/commit_trace_top.sv
test/trace_checker.sv
test/tb_commit_trace.sv

//--- run.sh
#!/bin/sh
# Build and run the commit trace testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_commit_trace \
    -f project.f -o tb_commit_trace > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/tb_commit_trace > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$SIM_LOG"; then
    exit 1
fi
exit 0
